// File: hdl/intc_config.svh
`ifndef INTC_CONFIG_SVH
`define INTC_CONFIG_SVH

// width of the command port data word
`define INTC_DATA_W 16

// number of interrupt sources and destinations
`define INTC_SRC_N 8
`define INTC_DST_N 4

// pointer widths for the counts above
`define INTC_SRC_IW $clog2(`INTC_SRC_N)
`define INTC_DST_IW $clog2(`INTC_DST_N)

`endif

// File: hdl/intc_dispatch.sv
`timescale 1ns/100ps
`include "intc_config.svh"

module intc_dispatch (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  intc_pkg::pi_op_t        pi_op_i,
	input  logic [`INTC_DATA_W-1:0] pi_data_i,
	output logic [`INTC_DATA_W-1:0] pi_data_o,
	intc_src_if.disp                src,
	intc_dst_if.disp                dst,
	output logic [`INTC_DST_N-1:0]  intrqstdst_o
);

	import intc_pkg::*;

	localparam int W      = `INTC_DATA_W;
	localparam int N_SRC  = `INTC_SRC_N;
	localparam int N_DST  = `INTC_DST_N;
	localparam int SRC_IW = `INTC_SRC_IW;
	localparam int DST_IW = `INTC_DST_IW;

	// decoded command strobes
	logic cmd_ack;
	logic cmd_intdst;
	logic cmd_ena;
	// argument fields, layout |idx|en|cmd| or |idx|cmd|
	logic [W-4:0] arg_idx3;
	logic [W-3:0] arg_idx2;
	logic ena_ok;
	logic intdst_ok;
	logic ack_in_range;
	logic ack_match;

	// one interrupt in flight at a time
	logic pending;
	// the pending interrupt came from INTDST, not from a source
	logic tgt_flag;
	logic [DST_IW-1:0] tgt_idx;

	// priority chain branches
	logic seeking;
	logic br_ack;
	logic br_scan;

	always_comb begin
		cmd_ack    = (pi_op_i == PI_RWOP) && (cmd_t'(pi_data_i[1:0]) == CMD_ACKINT);
		cmd_intdst = (pi_op_i == PI_RWOP) && (cmd_t'(pi_data_i[1:0]) == CMD_INTDST);
		cmd_ena    = (pi_op_i == PI_RWOP) && (cmd_t'(pi_data_i[1:0]) == CMD_ENAINT);
	end

	assign arg_idx3     = pi_data_i[W-1:3];
	assign arg_idx2     = pi_data_i[W-1:2];
	assign ena_ok       = (arg_idx3 < N_SRC);
	assign intdst_ok    = (arg_idx2 < N_DST);
	assign ack_in_range = (arg_idx3 < N_DST);
	// an ack only hits when something is pending on the named destination
	assign ack_match    = pending && (arg_idx3 == (W - 3)'(dst.dst_idx));

	// targeted interrupt still walking toward its destination
	assign seeking = tgt_flag && !dst.at_target;
	assign br_ack  = !cmd_ena && !cmd_intdst && !seeking && (pending || cmd_ack);
	assign br_scan = !cmd_ena && !cmd_intdst && !seeking && !pending && !cmd_ack;

	// strobes toward the scanner
	assign src.src_adv      = (br_ack && cmd_ack && ack_match) || (br_scan && !src.src_req);
	assign src.src_ack_hold = pending && !tgt_flag;
	assign src.en_we        = cmd_ena && ena_ok;
	assign src.en_idx       = pi_data_i[3 +: SRC_IW];
	assign src.en_val       = pi_data_i[2];

	// strobes toward the selector
	assign dst.dst_adv  = br_scan && src.src_req && !dst.dst_ok;
	assign dst.dst_home = br_ack && cmd_ack && ack_match;
	assign dst.seek     = !cmd_ena && !cmd_intdst && seeking;
	assign dst.seek_idx = tgt_idx;
	// ACKINT carries the destination enable bit, applied even on a miss
	assign dst.en_we    = br_ack && cmd_ack && ack_in_range;
	assign dst.en_idx   = pi_data_i[3 +: DST_IW];
	assign dst.en_val   = pi_data_i[2];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pending   <= 1'b0;
			tgt_flag  <= 1'b0;
			pi_data_o <= '0;
		end else if (cmd_ena) begin
			pi_data_o <= ena_ok ? W'(pi_data_i[3 +: SRC_IW]) : REPLY_INVALID;
		end else if (cmd_intdst) begin
			if (!intdst_ok) begin
				pi_data_o <= REPLY_INVALID;
			end else if (pending) begin
				pi_data_o <= REPLY_BUSY;
			end else begin
				pi_data_o <= W'(pi_data_i[2 +: DST_IW]);
				pending   <= 1'b1;
				tgt_flag  <= 1'b1;
			end
		end else if (br_ack) begin
			if (cmd_ack && ack_match) begin
				// source index back to software, -1 when nobody raised it
				pi_data_o <= tgt_flag ? REPLY_INVALID : W'(src.src_idx);
				pending   <= 1'b0;
				tgt_flag  <= 1'b0;
			end else if (cmd_ack) begin
				pi_data_o <= REPLY_BUSY;
			end
		end else if (br_scan && src.src_req && dst.dst_ok) begin
			pending <= 1'b1;
		end
	end

	// target held for the selector while it walks
	always_ff @(posedge clk_i) begin
		if (cmd_intdst && intdst_ok && !pending) begin
			tgt_idx <= pi_data_i[2 +: DST_IW];
		end
	end

	// request only once the pointer rests on the chosen destination
	always_comb begin
		for (int i = 0; i < N_DST; i++) begin
			intrqstdst_o[i] = pending && !seeking && (dst.dst_idx == DST_IW'(i));
		end
	end

endmodule

// File: hdl/intc_dst_if.sv
`timescale 1ns/100ps
`include "intc_config.svh"

interface intc_dst_if;

	// pointer to the destination under test
	logic [`INTC_DST_IW-1:0] dst_idx;
	// pointed destination may take the interrupt
	logic dst_ok;
	// step the pointer by one, wrapping
	logic dst_adv;
	// send the pointer back to destination 0
	logic dst_home;

	// targeted interrupt, selector walks to seek_idx on its own
	logic seek;
	logic [`INTC_DST_IW-1:0] seek_idx;
	// pointer sits on seek_idx
	logic at_target;

	// destination enable mask write
	logic en_we;
	logic [`INTC_DST_IW-1:0] en_idx;
	logic en_val;

	modport sel (
		output dst_idx, dst_ok, at_target,
		input  dst_adv, dst_home, seek, seek_idx,
		input  en_we, en_idx, en_val
	);

	modport disp (
		input  dst_idx, dst_ok, at_target,
		output dst_adv, dst_home, seek, seek_idx,
		output en_we, en_idx, en_val
	);

endinterface

// File: hdl/intc_dst_sel.sv
`timescale 1ns/100ps
`include "intc_config.svh"

module intc_dst_sel (
	input  logic                   clk_i,
	input  logic                   rst_i,
	intc_dst_if.sel                dst,
	input  logic [`INTC_DST_N-1:0] intrdydst_i,
	input  logic [`INTC_DST_N-1:0] intbestdst_i
);

	localparam int N  = `INTC_DST_N;
	localparam int IW = `INTC_DST_IW;

	// per-destination enable, all off after reset
	logic [N-1:0] dst_en;
	// destination pointer
	logic [IW-1:0] ptr;
	logic [IW-1:0] ptr_nxt;
	// some enabled destination reports best
	logic any_best;
	// a targeted interrupt still has to reach its destination
	logic seek_step;

	always_comb begin
		if (ptr == IW'(N - 1)) begin
			ptr_nxt = '0;
		end else begin
			ptr_nxt = ptr + 1'b1;
		end
	end

	assign any_best = |(intbestdst_i & dst_en);

	// best destination always wins
	// a plain ready one only counts when nobody enabled is best,
	// otherwise the pointer keeps moving until it finds the best one
	assign dst.dst_ok = dst_en[ptr] &&
		(intbestdst_i[ptr] || (!any_best && intrdydst_i[ptr]));

	// comparison alone, the dispatcher decides when it matters
	assign dst.at_target = (ptr == dst.seek_idx);

	assign seek_step = dst.seek && !dst.at_target;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ptr    <= '0;
			dst_en <= '0;
		end else begin
			if (dst.en_we) begin
				dst_en[dst.en_idx] <= dst.en_val;
			end
			// home after an ack so the lowest index is tried first
			if (dst.dst_home) begin
				ptr <= '0;
			end else if (dst.dst_adv || seek_step) begin
				ptr <= ptr_nxt;
			end
		end
	end

	assign dst.dst_idx = ptr;

endmodule

// File: hdl/intc_pkg.sv
`include "intc_config.svh"

package intc_pkg;

	// operation code on the command port
	// only a read-write does anything
	typedef enum logic [1:0] {
		PI_NOOP = 2'b00,
		PI_WROP = 2'b01,
		PI_RDOP = 2'b10,
		PI_RWOP = 2'b11
	} pi_op_t;

	// command field, low two bits of the data word
	typedef enum logic [1:0] {
		CMD_ACKINT = 2'b00,
		CMD_INTDST = 2'b01,
		CMD_ENAINT = 2'b10
	} cmd_t;

	// reply for an index out of range, or an ack of a targeted interrupt
	localparam logic [`INTC_DATA_W-1:0] REPLY_INVALID = '1;

	// reply when an interrupt is already pending
	// also used for an ack naming the wrong destination
	localparam logic [`INTC_DATA_W-1:0] REPLY_BUSY = {{(`INTC_DATA_W-1){1'b1}}, 1'b0};

endpackage

// File: hdl/intc_src_if.sv
`timescale 1ns/100ps
`include "intc_config.svh"

interface intc_src_if;

	// pointer to the source being polled
	logic [`INTC_SRC_IW-1:0] src_idx;
	// pointed source is enabled and raising its request
	logic src_req;
	// step the pointer to the next source
	logic src_adv;
	// pending interrupt came from the pointed source
	logic src_ack_hold;

	// source enable mask write
	logic en_we;
	logic [`INTC_SRC_IW-1:0] en_idx;
	logic en_val;

	modport scan (
		output src_idx, src_req,
		input  src_adv, src_ack_hold,
		input  en_we, en_idx, en_val
	);

	modport disp (
		input  src_idx, src_req,
		output src_adv, src_ack_hold,
		output en_we, en_idx, en_val
	);

endinterface

// File: hdl/intc_src_scan.sv
`timescale 1ns/100ps
`include "intc_config.svh"

module intc_src_scan (
	input  logic                   clk_i,
	input  logic                   rst_i,
	intc_src_if.scan               src,
	input  logic [`INTC_SRC_N-1:0] intrqstsrc_i,
	output logic [`INTC_SRC_N-1:0] intrdysrc_o
);

	localparam int N  = `INTC_SRC_N;
	localparam int IW = `INTC_SRC_IW;

	// per-source enable, all off after reset
	logic [N-1:0] src_en;
	// round-robin poll pointer
	logic [IW-1:0] ptr;
	logic [IW-1:0] ptr_nxt;

	// wrap at the last source, count may not be a power of two
	always_comb begin
		if (ptr == IW'(N - 1)) begin
			ptr_nxt = '0;
		end else begin
			ptr_nxt = ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ptr    <= '0;
			src_en <= '0;
		end else begin
			// mask write and pointer step may land on the same edge
			if (src.en_we) begin
				src_en[src.en_idx] <= src.en_val;
			end
			if (src.src_adv) begin
				ptr <= ptr_nxt;
			end
		end
	end

	assign src.src_idx = ptr;

	// a request only counts from an enabled source
	assign src.src_req = src_en[ptr] && intrqstsrc_i[ptr];

	// ready goes low on the pointed source while its interrupt waits for the ack
	// the source is expected to drop its request on that falling edge
	always_comb begin
		for (int i = 0; i < N; i++) begin
			intrdysrc_o[i] = !(src.src_ack_hold && (ptr == IW'(i)));
		end
	end

endmodule

// File: hdl/intc_top.sv
`timescale 1ns/100ps
`include "intc_config.svh"

module intc_top (
	input  logic                    clk_i,
	input  logic                    rst_i,

	// command port
	input  intc_pkg::pi_op_t        pi_op_i,
	input  logic [`INTC_DATA_W-1:0] pi_data_i,
	output logic [`INTC_DATA_W-1:0] pi_data_o,

	// destination side, one bit per destination
	output logic [`INTC_DST_N-1:0]  intrqstdst_o,
	input  logic [`INTC_DST_N-1:0]  intrdydst_i,
	input  logic [`INTC_DST_N-1:0]  intbestdst_i,

	// source side, one bit per source
	input  logic [`INTC_SRC_N-1:0]  intrqstsrc_i,
	output logic [`INTC_SRC_N-1:0]  intrdysrc_o
);

	// scanner to dispatcher
	intc_src_if src_bus ();
	// selector to dispatcher
	intc_dst_if dst_bus ();

	// polls the sources round-robin
	intc_src_scan u_src_scan (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.src          (src_bus.scan),
		.intrqstsrc_i (intrqstsrc_i),
		.intrdysrc_o  (intrdysrc_o)
	);

	// finds a destination willing to take the interrupt
	intc_dst_sel u_dst_sel (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.dst          (dst_bus.sel),
		.intrdydst_i  (intrdydst_i),
		.intbestdst_i (intbestdst_i)
	);

	// commands, pending state and the destination request
	intc_dispatch u_dispatch (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.pi_op_i      (pi_op_i),
		.pi_data_i    (pi_data_i),
		.pi_data_o    (pi_data_o),
		.src          (src_bus.disp),
		.dst          (dst_bus.disp),
		.intrqstdst_o (intrqstdst_o)
	);

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module intc_tb -o intc_sim &&
./obj_dir/intc_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -q "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb.f
+incdir+hdl
hdl/intc_pkg.sv
hdl/intc_src_if.sv
hdl/intc_dst_if.sv
hdl/intc_src_scan.sv
hdl/intc_dst_sel.sv
hdl/intc_dispatch.sv
hdl/intc_top.sv
testbench/intc_chk.sv
testbench/intc_tb.sv

// File: testbench/intc_chk.sv
`timescale 1ns/100ps
`include "intc_config.svh"

module intc_chk (
	input logic                    clk_i,
	input logic                    rst_i,
	input logic [`INTC_DATA_W-1:0] pi_data_o,
	input logic [`INTC_DST_N-1:0]  intrqstdst_o,
	input logic [`INTC_SRC_N-1:0]  intrdysrc_o
);

	// failed assertions so far, read by the testbench at the end
	int fails = 0;

	// only one interrupt in flight, so at most one destination is asked
	dst_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0(intrqstdst_o))
		else begin
			$error("more than one destination request is high");
			fails++;
		end

	// a single source waits for its ack at any time
	src_rdy_single: assert property (@(posedge clk_i) disable iff (rst_i)
		$countones(~intrdysrc_o) <= 1)
		else begin
			$error("more than one source ready output is low");
			fails++;
		end

	// a held source needs a destination request that carries it
	src_rdy_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
		!(&intrdysrc_o) |-> (|intrqstdst_o))
		else begin
			$error("source ready is low with no destination request");
			fails++;
		end

	// outputs sit in their idle state right after a reset edge
	reset_quiet: assert property (@(posedge clk_i)
		rst_i |=> (intrqstdst_o == '0 && (&intrdysrc_o) && pi_data_o == '0))
		else begin
			$error("outputs not idle after a reset edge");
			fails++;
		end

endmodule

// File: testbench/intc_tb.sv
`timescale 1ns/100ps
`include "intc_config.svh"

module intc_tb;

	import intc_pkg::*;

	localparam int W  = `INTC_DATA_W;
	localparam int NS = `INTC_SRC_N;
	localparam int ND = `INTC_DST_N;
	// replies for a bad index (-1) and for a busy or mismatched request (-2)
	localparam logic [W-1:0] R_INV  = '1;
	localparam logic [W-1:0] R_BUSY = {{(W-1){1'b1}}, 1'b0};
	// cycles any wait may take before giving up
	localparam int WAIT_MAX = 64;

	logic clk_i = 1'b0;
	logic rst_i;
	pi_op_t pi_op_i;
	logic [W-1:0] pi_data_i;
	logic [W-1:0] pi_data_o;
	logic [ND-1:0] intrqstdst_o;
	logic [ND-1:0] intrdydst_i;
	logic [ND-1:0] intbestdst_i;
	logic [NS-1:0] intrqstsrc_i;
	logic [NS-1:0] intrdysrc_o;

	integer seed = 32'h0749cbe4;
	int errors = 0;
	int tests = 0;
	// error count when the current test started
	int test_err;
	string tname;
	// destination enables as software last wrote them
	logic [ND-1:0] dst_en;
	logic [ND-1:0] exp_dst;
	logic hit;
	int s;
	int s2;
	int d;
	int b;

	always #20 clk_i = ~clk_i;

	intc_top DUT (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.pi_op_i      (pi_op_i),
		.pi_data_i    (pi_data_i),
		.pi_data_o    (pi_data_o),
		.intrqstdst_o (intrqstdst_o),
		.intrdydst_i  (intrdydst_i),
		.intbestdst_i (intbestdst_i),
		.intrqstsrc_i (intrqstsrc_i),
		.intrdysrc_o  (intrdysrc_o)
	);

	bind intc_top intc_chk u_chk (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.pi_data_o    (pi_data_o),
		.intrqstdst_o (intrqstdst_o),
		.intrdysrc_o  (intrdysrc_o)
	);

	// command words are |idx|en|cmd| for ack and enable and |idx|cmd| for a target
	function automatic logic [W-1:0] ena_word(input int idx, input logic en);
		return (W'(idx) << 3) | (W'(en) << 2) | W'(CMD_ENAINT);
	endfunction

	function automatic logic [W-1:0] ack_word(input int idx, input logic en);
		return (W'(idx) << 3) | (W'(en) << 2) | W'(CMD_ACKINT);
	endfunction

	function automatic logic [W-1:0] intdst_word(input int idx);
		return (W'(idx) << 2) | W'(CMD_INTDST);
	endfunction

	// lowest set bit of a destination mask
	function automatic int low_idx(input logic [ND-1:0] mask);
		int idx;
		idx = 0;
		for (int i = ND - 1; i >= 0; i--) begin
			if (mask[i]) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	// pointer starts at 0 and stops on the first destination allowed to take it
	// best ones only, unless no enabled destination is best
	function automatic logic [ND-1:0] pick_dst(input logic [ND-1:0] en,
		input logic [ND-1:0] rdy, input logic [ND-1:0] best);
		logic [ND-1:0] ok;
		logic [ND-1:0] sel;
		ok = (|(en & best)) ? (en & best) : (en & rdy);
		sel = '0;
		if (ok != '0) begin
			sel[low_idx(ok)] = 1'b1;
		end
		return sel;
	endfunction

	task automatic start_test(input string name);
		tname = name;
		test_err = errors;
		tests++;
	endtask

	task automatic end_test();
		$display("test %s: %s", tname, (errors == test_err) ? "ok" : "failed");
	endtask

	task automatic check(input string what, input logic [W-1:0] exp, input logic [W-1:0] act);
		assert (act === exp) else begin
			$display("Fail %s, %s: expected %h, actual %h", tname, what, exp, act);
			errors++;
		end
	endtask

	// one read-write command whose reply is read one edge later
	task automatic cmd_check(input string what, input logic [W-1:0] word,
		input logic [W-1:0] exp);
		@(posedge clk_i);
		#2;
		pi_op_i = PI_RWOP;
		pi_data_i = word;
		@(posedge clk_i);
		#2;
		pi_op_i = PI_NOOP;
		pi_data_i = '0;
		check(what, exp, pi_data_o);
	endtask

	// wait for any destination request
	task automatic wait_request(output logic seen);
		int n;
		n = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_MAX) begin
			@(posedge clk_i);
			#2;
			seen = |intrqstdst_o;
			n++;
		end
		assert (seen) else begin
			$display("%s: no destination request rose within %0d cycles", tname, WAIT_MAX);
			errors++;
		end
	endtask

	// raise one source, then check the chosen destination and the held ready
	task automatic dispatch_from(input int src, input logic [ND-1:0] exp);
		logic seen;
		logic [NS-1:0] rdy_exp;
		rdy_exp = '1;
		rdy_exp[src] = 1'b0;
		intrqstsrc_i[src] = 1'b1;
		wait_request(seen);
		check("destination request", W'(exp), W'(intrqstdst_o));
		check("source ready held", W'(rdy_exp), W'(intrdysrc_o));
		// source drops its request once ready goes low
		intrqstsrc_i[src] = 1'b0;
	endtask

	// a disabled source must never reach a destination
	task automatic expect_quiet(input int src);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		intrqstsrc_i[src] = 1'b1;
		while (!seen && n < WAIT_MAX) begin
			@(posedge clk_i);
			#2;
			seen = |intrqstdst_o;
			n++;
		end
		assert (!seen) else begin
			$display("%s: disabled source %0d was dispatched", tname, src);
			errors++;
		end
		intrqstsrc_i[src] = 1'b0;
	endtask

	initial begin
		rst_i = 1'b1;
		pi_op_i = PI_NOOP;
		pi_data_i = '0;
		intrdydst_i = '0;
		intbestdst_i = '0;
		intrqstsrc_i = '0;
		dst_en = '0;
		repeat (16) @(posedge clk_i);
		#2;
		rst_i = 1'b0;

		start_test("enaint");
		s = {$random(seed)} % NS;
		cmd_check("in range", ena_word(s, 1'b1), W'(s));
		cmd_check("out of range", ena_word(NS, 1'b1), R_INV);
		end_test();

		start_test("source dispatch");
		// nothing pending, so each enable through ACKINT answers busy
		for (int i = 0; i < ND; i++) begin
			cmd_check("destination enable", ack_word(i, 1'b1), R_BUSY);
		end
		dst_en = '1;
		intrdydst_i = '1;
		exp_dst = pick_dst(dst_en, intrdydst_i, intbestdst_i);
		dispatch_from(s, exp_dst);
		cmd_check("ack", ack_word(low_idx(exp_dst), 1'b1), W'(s));
		check("request after ack", '0, W'(intrqstdst_o));
		check("ready after ack", W'({NS{1'b1}}), W'(intrdysrc_o));
		end_test();

		start_test("wrong ack and disabled source");
		s2 = (s + 1 + {$random(seed)} % (NS - 1)) % NS;
		cmd_check("enable source", ena_word(s2, 1'b1), W'(s2));
		exp_dst = pick_dst(dst_en, intrdydst_i, intbestdst_i);
		dispatch_from(s2, exp_dst);
		d = (low_idx(exp_dst) + 1) % ND;
		cmd_check("wrong ack", ack_word(d, 1'b1), R_BUSY);
		check("request held", W'(exp_dst), W'(intrqstdst_o));
		cmd_check("ack", ack_word(low_idx(exp_dst), 1'b1), W'(s2));
		cmd_check("disable source", ena_word(s2, 1'b0), W'(s2));
		expect_quiet(s2);
		end_test();

		start_test("intdst");
		// pointer rests on 0 after the last ack, so a target above it needs a walk
		d = 1 + {$random(seed)} % (ND - 1);
		cmd_check("target", intdst_word(d), W'(d));
		wait_request(hit);
		exp_dst = '0;
		exp_dst[d] = 1'b1;
		check("target request", W'(exp_dst), W'(intrqstdst_o));
		check("sources untouched", W'({NS{1'b1}}), W'(intrdysrc_o));
		cmd_check("second target", intdst_word((d + 1) % ND), R_BUSY);
		cmd_check("out of range", intdst_word(ND + 1), R_INV);
		cmd_check("ack targeted", ack_word(d, 1'b1), R_INV);
		check("request after ack", '0, W'(intrqstdst_o));
		end_test();

		start_test("preference");
		// best one sits above destination 0 so the pointer passes a ready one first
		b = 1 + {$random(seed)} % (ND - 1);
		intbestdst_i = '0;
		intbestdst_i[b] = 1'b1;
		exp_dst = pick_dst(dst_en, intrdydst_i, intbestdst_i);
		dispatch_from(s, exp_dst);
		// ack clears the enable of the best one
		cmd_check("ack and disable best", ack_word(b, 1'b0), W'(s));
		dst_en[b] = 1'b0;
		exp_dst = pick_dst(dst_en, intrdydst_i, intbestdst_i);
		dispatch_from(s, exp_dst);
		cmd_check("ack", ack_word(low_idx(exp_dst), 1'b1), W'(s));
		end_test();

		$display("tests run: %0d, check errors: %0d, assertion errors: %0d",
			tests, errors, DUT.u_chk.fails);
		if (errors == 0 && DUT.u_chk.fails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
